// File: rtl/rob_pkg.sv
package rob_pkg;

    // buffer geometry
    // tag 0 is reserved to mean no producer, live tags are 1 to ROB_DEPTH
    localparam int ROB_DEPTH = 7;
    localparam int TAG_W     = 3;
    // occupancy counter must reach ROB_DEPTH
    localparam int CNT_W     = 3;

    // first and last live tag, pointers wrap between them
    localparam logic [TAG_W-1:0] FIRST_TAG = TAG_W'(1);
    localparam logic [TAG_W-1:0] LAST_TAG  = TAG_W'(ROB_DEPTH);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(ROB_DEPTH);

    // result bus ports
    localparam int NUM_CDB = 2;

    // architectural state
    localparam int REG_W    = 5;
    localparam int NUM_REGS = 32;
    localparam int XLEN     = 32;

    // instruction class
    typedef enum logic [0:0] {
        op_alu   = 1'b0,
        op_store = 1'b1
    } op_kind_t;

    // decoded instruction, addr only meaningful for stores
    typedef struct packed {
        op_kind_t          kind;
        logic [REG_W-1:0]  rd;
        logic [XLEN-1:0]   addr;
    } dispatch_t;

    // one common data bus port
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   value;
    } cdb_t;

    // one reorder buffer slot
    typedef struct packed {
        logic              busy;
        logic              done;
        dispatch_t         op;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   value;
    } rob_entry_t;

    // retirement record, to regfile and store unit
    typedef struct packed {
        op_kind_t          kind;
        logic [REG_W-1:0]  rd;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   value;
    } commit_t;

endpackage

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  flush,
    input  logic                                  dispatch,
    input  rob_pkg::dispatch_t                    dispatch_op,
    input  rob_pkg::cdb_t [rob_pkg::NUM_CDB-1:0]  cdb,
    input  logic                                  store_done,
    input  logic                                  store_busy,
    output logic [rob_pkg::TAG_W-1:0]             alloc_tag,
    output logic                                  full,
    output logic                                  empty,
    output logic                                  dispatch_accept,
    output logic                                  commit_valid,
    output rob_pkg::commit_t                      commit_data,
    output logic                                  store_req
);

    // slot 0 stays idle, tags index the array directly
    rob_pkg::rob_entry_t entries [0:rob_pkg::ROB_DEPTH];

    // oldest entry and next free slot
    logic [rob_pkg::TAG_W-1:0] head;
    logic [rob_pkg::TAG_W-1:0] tail;
    // exact occupancy, 0 to ROB_DEPTH
    logic [rob_pkg::CNT_W-1:0] count;
    // store head already handed to the store unit
    logic                      store_pending;

    rob_pkg::rob_entry_t       head_e;
    rob_pkg::commit_t          head_commit;
    logic                      accept;
    logic                      retire_alu;
    logic                      start_store;
    logic                      retire_store;
    logic                      retire;

    // step a pointer, wrapping past the last tag back to 1
    function automatic logic [rob_pkg::TAG_W-1:0] next_tag(
        input logic [rob_pkg::TAG_W-1:0] t
    );
        if (t == rob_pkg::LAST_TAG) begin
            return rob_pkg::FIRST_TAG;
        end
        return t + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign full      = (count == rob_pkg::FULL_COUNT);
    assign empty     = (count == '0);

    // dispatch taken whenever there is room
    assign accept = dispatch && !full;
    // only ALU results claim a destination register
    assign dispatch_accept = accept && (dispatch_op.kind == rob_pkg::op_alu);

    assign head_e = entries[head];

    // head record as seen by regfile and store unit
    always_comb begin
        head_commit.kind  = head_e.op.kind;
        head_commit.rd    = head_e.op.rd;
        head_commit.tag   = head_e.tag;
        head_commit.addr  = head_e.op.addr;
        head_commit.value = head_e.value;
    end

    // done ALU head leaves at once
    assign retire_alu = head_e.busy && head_e.done
                        && (head_e.op.kind == rob_pkg::op_alu);
    // done store head asks the store unit once, and only when it is free
    assign start_store = head_e.busy && head_e.done
                         && (head_e.op.kind == rob_pkg::op_store)
                         && !store_pending && !store_busy;
    // a store_done without a pending request belongs to a flushed store
    assign retire_store = store_done && store_pending;
    assign retire       = retire_alu || retire_store;

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head          <= rob_pkg::FIRST_TAG;
            tail          <= rob_pkg::FIRST_TAG;
            count         <= '0;
            store_pending <= 1'b0;
            commit_valid  <= 1'b0;
            store_req     <= 1'b0;
            for (int i = 0; i <= rob_pkg::ROB_DEPTH; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            commit_valid <= retire;
            store_req    <= start_store;

            // record latched for an ALU commit or a store request
            // store record stays put until store_done
            if (retire_alu || start_store) begin
                commit_data <= head_commit;
            end

            // result capture, both ports in parallel
            for (int p = 0; p < rob_pkg::NUM_CDB; p++) begin
                if (cdb[p].valid && entries[cdb[p].tag].busy
                    && !entries[cdb[p].tag].done) begin
                    entries[cdb[p].tag].done  <= 1'b1;
                    entries[cdb[p].tag].value <= cdb[p].value;
                end
            end

            // enqueue at tail
            // tail slot is free here, so no clash with capture or retire
            if (accept) begin
                entries[tail].busy  <= 1'b1;
                entries[tail].done  <= 1'b0;
                entries[tail].op    <= dispatch_op;
                entries[tail].tag   <= tail;
                entries[tail].value <= '0;
                tail                <= next_tag(tail);
            end

            // dequeue at head
            if (retire) begin
                entries[head].busy <= 1'b0;
                entries[head].done <= 1'b0;
                head               <= next_tag(head);
            end

            if (retire_store) begin
                store_pending <= 1'b0;
            end else if (start_store) begin
                store_pending <= 1'b1;
            end

            // simultaneous enqueue and dequeue leave count alone
            case ({accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/rename_regfile.sv
`timescale 1ns/1ns

module rename_regfile (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       dispatch_we,
    input  logic [rob_pkg::REG_W-1:0]  dispatch_rd,
    input  logic [rob_pkg::TAG_W-1:0]  dispatch_tag,
    input  logic                       commit_valid,
    input  rob_pkg::commit_t           commit_data,
    input  logic [rob_pkg::REG_W-1:0]  src_reg,
    output logic [rob_pkg::TAG_W-1:0]  src_tag,
    output logic [rob_pkg::XLEN-1:0]   src_value
);

    // architectural values
    logic [rob_pkg::XLEN-1:0]  regs [rob_pkg::NUM_REGS];
    // youngest in-flight producer per register, 0 when none
    logic [rob_pkg::TAG_W-1:0] tags [rob_pkg::NUM_REGS];

    logic commit_alu;
    logic rename_en;
    logic owner_match;

    // x0 is never written
    assign commit_alu = commit_valid
                        && (commit_data.kind == rob_pkg::op_alu)
                        && (commit_data.rd != '0);

    assign rename_en = dispatch_we && (dispatch_rd != '0);

    // release the rename only if no younger writer took over
    assign owner_match = (tags[commit_data.rd] == commit_data.tag);

    // register values survive a flush
    // retired work is architectural
    always_ff @(posedge clk) begin
        if (rst_n && commit_alu) begin
            regs[commit_data.rd] <= commit_data.value;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            for (int r = 0; r < rob_pkg::NUM_REGS; r++) begin
                tags[r] <= '0;
            end
        end else begin
            if (commit_alu && owner_match) begin
                tags[commit_data.rd] <= '0;
            end
            // later assignment wins, so dispatch beats commit on the same rd
            if (rename_en) begin
                tags[dispatch_rd] <= dispatch_tag;
            end
        end
    end

    // operand lookup
    // tag of x0 is never set, so it always reads 0
    assign src_tag   = tags[src_reg];
    assign src_value = (src_reg == '0) ? '0 : regs[src_reg];

endmodule

// File: rtl/store_commit.sv
`timescale 1ns/1ns

module store_commit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      store_req,
    input  rob_pkg::commit_t          commit_data,
    input  logic                      mem_ack,
    output logic                      store_busy,
    output logic                      store_done,
    output logic                      mem_req,
    output logic [rob_pkg::XLEN-1:0]  mem_addr,
    output logic [rob_pkg::XLEN-1:0]  mem_data
);

    // waiting, write outstanding, completion pulse
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_mem  = 2'd1,
        st_done = 2'd2
    } state_t;

    state_t state;

    // state transitions
    // a flush does not reach here, an issued write always completes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (store_req) begin
                        state <= st_mem;
                    end
                end
                st_mem: begin
                    if (mem_ack) begin
                        state <= st_done;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address and data held for the whole write
    always_ff @(posedge clk) begin
        if (state == st_idle && store_req) begin
            mem_addr <= commit_data.addr;
            mem_data <= commit_data.value;
        end
    end

    assign mem_req    = (state == st_mem);
    // one cycle after mem_ack
    assign store_done = (state == st_done);
    assign store_busy = (state != st_idle);

endmodule

// File: rtl/rob_core.sv
`timescale 1ns/1ns

module rob_core (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  flush,
    input  logic                                  dispatch,
    input  rob_pkg::dispatch_t                    dispatch_op,
    input  rob_pkg::cdb_t [rob_pkg::NUM_CDB-1:0]  cdb,
    input  logic [rob_pkg::REG_W-1:0]             src_reg,
    input  logic                                  mem_ack,
    output logic [rob_pkg::TAG_W-1:0]             alloc_tag,
    output logic                                  full,
    output logic                                  empty,
    output logic [rob_pkg::TAG_W-1:0]             src_tag,
    output logic [rob_pkg::XLEN-1:0]              src_value,
    output logic                                  commit_valid,
    output rob_pkg::commit_t                      commit_data,
    output logic                                  mem_req,
    output logic [rob_pkg::XLEN-1:0]              mem_addr,
    output logic [rob_pkg::XLEN-1:0]              mem_data
);

    // buffer to rename table
    logic dispatch_accept;
    // buffer and store unit handshake
    logic store_req;
    logic store_busy;
    logic store_done;

    reorder_buffer reorder_buffer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .dispatch        (dispatch),
        .dispatch_op     (dispatch_op),
        .cdb             (cdb),
        .store_done      (store_done),
        .store_busy      (store_busy),
        .alloc_tag       (alloc_tag),
        .full            (full),
        .empty           (empty),
        .dispatch_accept (dispatch_accept),
        .commit_valid    (commit_valid),
        .commit_data     (commit_data),
        .store_req       (store_req)
    );

    // new owner of rd is the tag being allocated this cycle
    rename_regfile rename_regfile_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .dispatch_we  (dispatch_accept),
        .dispatch_rd  (dispatch_op.rd),
        .dispatch_tag (alloc_tag),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .src_reg      (src_reg),
        .src_tag      (src_tag),
        .src_value    (src_value)
    );

    store_commit store_commit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_req   (store_req),
        .commit_data (commit_data),
        .mem_ack     (mem_ack),
        .store_busy  (store_busy),
        .store_done  (store_done),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_data    (mem_data)
    );

endmodule

// File: testbench/rob_clock.sv
`timescale 1ns/1ns

module rob_clock (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 5 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: testbench/rob_properties.sv
`timescale 1ns/1ns

module rob_properties (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        flush,
    input logic                        empty,
    input logic                        full,
    input logic [rob_pkg::TAG_W-1:0]   tail,
    input logic                        commit_valid,
    input logic                        store_req
);

    // a commit needs an occupied buffer one cycle earlier
    commit_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> !$past(empty))
        else $error("commit_valid seen while the buffer was empty");

    // nothing enters a full buffer, so its tail stays put
    no_accept_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (full && !flush) |=> (tail == $past(tail)))
        else $error("dispatch accepted while full");

    // store request is a single cycle pulse
    store_req_single: assert property (@(posedge clk) disable iff (!rst_n || flush)
        store_req |=> !store_req)
        else $error("store_req high in two consecutive cycles");

endmodule

bind reorder_buffer rob_properties rob_properties_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .empty        (empty),
    .full         (full),
    .tail         (tail),
    .commit_valid (commit_valid),
    .store_req    (store_req)
);

// File: testbench/rob_tb.sv
`timescale 1ns/1ns

module rob_tb;

    // cycle budget per test, watchdog uses the total
    localparam int TEST_BUDGET = 400;
    localparam int NUM_TESTS   = 5;
    localparam int WAIT_LIMIT  = 40;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  flush;
    logic                                  dispatch;
    rob_pkg::dispatch_t                    dispatch_op;
    rob_pkg::cdb_t [rob_pkg::NUM_CDB-1:0]  cdb;
    logic [rob_pkg::REG_W-1:0]             src_reg;
    logic                                  mem_ack;
    logic [rob_pkg::TAG_W-1:0]             alloc_tag;
    logic                                  full;
    logic                                  empty;
    logic [rob_pkg::TAG_W-1:0]             src_tag;
    logic [rob_pkg::XLEN-1:0]              src_value;
    logic                                  commit_valid;
    rob_pkg::commit_t                      commit_data;
    logic                                  mem_req;
    logic [rob_pkg::XLEN-1:0]              mem_addr;
    logic [rob_pkg::XLEN-1:0]              mem_data;

    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int seed = 32'hde5e;
    // shadow of architectural registers that tests have written
    logic [31:0] reg_model [32];
    bit          reg_known [32];
    // expected tail tag and occupancy, tracked from the tag rules
    logic [2:0]  exp_tail;
    int          exp_count;

    rob_clock rob_clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rob_core rob_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .dispatch     (dispatch),
        .dispatch_op  (dispatch_op),
        .cdb          (cdb),
        .src_reg      (src_reg),
        .mem_ack      (mem_ack),
        .alloc_tag    (alloc_tag),
        .full         (full),
        .empty        (empty),
        .src_tag      (src_tag),
        .src_value    (src_value),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // tags run 1..7 and wrap back to 1
    function automatic logic [2:0] wrap_tag(input logic [2:0] t);
        return (t == 3'd7) ? 3'd1 : t + 3'd1;
    endfunction

    function automatic logic [4:0] random_rd();
        return 5'(($random(seed) & 32'h1e) + 1);
    endfunction

    // call on a falling edge, returns on the next one
    task automatic dispatch_one(input string name, input rob_pkg::op_kind_t kind,
                                input logic [4:0] rd, input logic [31:0] addr,
                                output logic [2:0] tag);
        check_value(name, 32'(exp_tail), 32'(alloc_tag));
        dispatch         = 1'b1;
        dispatch_op.kind = kind;
        dispatch_op.rd   = rd;
        dispatch_op.addr = addr;
        tag              = exp_tail;
        @(negedge clk);
        dispatch = 1'b0;
        // a full buffer drops the dispatch and keeps its tail
        if (exp_count < 7) begin
            exp_tail = wrap_tag(exp_tail);
            exp_count++;
        end
    endtask

    task automatic drive_port(input int p, input logic [2:0] tag, input logic [31:0] value);
        cdb[p].valid = 1'b1;
        cdb[p].tag   = tag;
        cdb[p].value = value;
    endtask

    task automatic send_result(input logic [2:0] tag, input logic [31:0] value);
        drive_port(0, tag, value);
        @(negedge clk);
        cdb = '0;
    endtask

    task automatic send_pair(input logic [2:0] tag_a, input logic [31:0] value_a,
                             input logic [2:0] tag_b, input logic [31:0] value_b);
        drive_port(0, tag_a, value_a);
        drive_port(1, tag_b, value_b);
        @(negedge clk);
        cdb = '0;
    endtask

    // next commit pulse, sampled on falling edges
    task automatic wait_commit(input string name, output rob_pkg::commit_t c);
        int n;
        n = 0;
        c = '0;
        do begin
            @(negedge clk);
            n++;
        end while (!commit_valid && n < WAIT_LIMIT);
        if (commit_valid) begin
            c = commit_data;
            exp_count--;
        end else begin
            $display("%s: no commit arrived within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end
    endtask

    // lookup mid low phase, back on a falling edge afterwards
    task automatic read_reg(input logic [4:0] rd, output logic [2:0] tag,
                            output logic [31:0] value);
        src_reg = rd;
        #1;
        tag   = src_tag;
        value = src_value;
        @(negedge clk);
    endtask

    task automatic expect_alu_commit(input string name, input logic [2:0] tag,
                                     input logic [4:0] rd, input logic [31:0] value);
        rob_pkg::commit_t c;
        wait_commit(name, c);
        check_value(name, 32'(tag), 32'(c.tag));
        check_value(name, value, c.value);
        check_value(name, 32'(rd), 32'(c.rd));
        reg_model[rd] = value;
        reg_known[rd] = 1'b1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed", name);
            tests_failed++;
        end
    endtask

    // three results back to front, commits still come out in order
    task automatic test_in_order();
        logic [2:0]  tags [3];
        logic [4:0]  rds [3];
        logic [31:0] vals [3];
        logic [4:0]  base;
        logic [2:0]  t;
        logic [31:0] v;
        int          e0;
        e0 = errors;
        base = random_rd();
        for (int i = 0; i < 3; i++) begin
            rds[i]  = 5'(((int'(base) + i) % 31) + 1);
            vals[i] = $random(seed);
            dispatch_one("in_order", rob_pkg::op_alu, rds[i], 32'h0, tags[i]);
        end
        for (int i = 2; i >= 0; i--) begin
            send_result(tags[i], vals[i]);
        end
        for (int i = 0; i < 3; i++) begin
            expect_alu_commit("in_order", tags[i], rds[i], vals[i]);
        end
        @(negedge clk);
        for (int i = 0; i < 3; i++) begin
            read_reg(rds[i], t, v);
            check_value("in_order", vals[i], v);
            check_value("in_order", 32'd0, 32'(t));
        end
        report_test("in_order", e0);
    endtask

    // younger writer keeps ownership until it retires
    task automatic test_renaming();
        logic [4:0]  rd;
        logic [2:0]  tag_a;
        logic [2:0]  tag_b;
        logic [2:0]  t;
        logic [31:0] v;
        logic [31:0] val_a;
        logic [31:0] val_b;
        int          e0;
        e0 = errors;
        rd    = random_rd();
        val_a = $random(seed);
        val_b = $random(seed);
        @(negedge clk);
        dispatch_one("renaming", rob_pkg::op_alu, rd, 32'h0, tag_a);
        read_reg(rd, t, v);
        check_value("renaming", 32'(tag_a), 32'(t));
        dispatch_one("renaming", rob_pkg::op_alu, rd, 32'h0, tag_b);
        read_reg(rd, t, v);
        check_value("renaming", 32'(tag_b), 32'(t));
        @(negedge clk);
        send_result(tag_a, val_a);
        expect_alu_commit("renaming", tag_a, rd, val_a);
        @(negedge clk);
        read_reg(rd, t, v);
        check_value("renaming", 32'(tag_b), 32'(t));
        check_value("renaming", val_a, v);
        @(negedge clk);
        send_result(tag_b, val_b);
        expect_alu_commit("renaming", tag_b, rd, val_b);
        @(negedge clk);
        read_reg(rd, t, v);
        check_value("renaming", 32'd0, 32'(t));
        check_value("renaming", val_b, v);
        report_test("renaming", e0);
    endtask

    task automatic test_full_wrap();
        logic [2:0]  tags [7];
        logic [4:0]  rds [7];
        logic [31:0] vals [7];
        logic [2:0]  extra [2];
        logic [31:0] extra_val [2];
        logic [4:0]  extra_rd [2];
        int          e0;
        e0 = errors;
        @(negedge clk);
        check_value("full_wrap", 32'd1, 32'(empty));
        for (int i = 0; i < 7; i++) begin
            rds[i]  = random_rd();
            vals[i] = $random(seed);
            dispatch_one("full_wrap", rob_pkg::op_alu, rds[i], 32'h0, tags[i]);
        end
        check_value("full_wrap", 32'd1, 32'(full));
        // eighth dispatch is dropped
        dispatch_one("full_wrap", rob_pkg::op_alu, random_rd(), 32'h0, extra[0]);
        check_value("full_wrap", 32'(tags[0]), 32'(alloc_tag));
        check_value("full_wrap", 32'd1, 32'(full));
        // youngest first so the head finishes last
        send_pair(tags[6], vals[6], tags[5], vals[5]);
        send_pair(tags[4], vals[4], tags[3], vals[3]);
        send_pair(tags[2], vals[2], tags[1], vals[1]);
        send_result(tags[0], vals[0]);
        for (int i = 0; i < 7; i++) begin
            expect_alu_commit("full_wrap", tags[i], rds[i], vals[i]);
        end
        @(negedge clk);
        check_value("full_wrap", 32'd1, 32'(empty));
        check_value("full_wrap", 32'd0, 32'(full));
        for (int i = 0; i < 2; i++) begin
            extra_rd[i]  = random_rd();
            extra_val[i] = $random(seed);
            dispatch_one("full_wrap", rob_pkg::op_alu, extra_rd[i], 32'h0, extra[i]);
        end
        send_pair(extra[0], extra_val[0], extra[1], extra_val[1]);
        expect_alu_commit("full_wrap", extra[0], extra_rd[0], extra_val[0]);
        expect_alu_commit("full_wrap", extra[1], extra_rd[1], extra_val[1]);
        @(negedge clk);
        check_value("full_wrap", 32'd1, 32'(empty));
        report_test("full_wrap", e0);
    endtask

    // done ALU op waits behind a store until memory acknowledges
    task automatic test_store_hold();
        logic [2:0]       tag_s;
        logic [2:0]       tag_a;
        logic [4:0]       rd;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      val_a;
        rob_pkg::commit_t c;
        int               n;
        int               delay;
        int               e0;
        e0 = errors;
        addr  = $random(seed);
        data  = $random(seed);
        val_a = $random(seed);
        rd    = random_rd();
        delay = 1 + ($random(seed) & 7);
        @(negedge clk);
        dispatch_one("store_hold", rob_pkg::op_store, 5'd0, addr, tag_s);
        dispatch_one("store_hold", rob_pkg::op_alu, rd, 32'h0, tag_a);
        send_result(tag_a, val_a);
        send_result(tag_s, data);
        n = 0;
        while (!mem_req && n < WAIT_LIMIT) begin
            check_value("store_hold", 32'd0, 32'(commit_valid));
            @(negedge clk);
            n++;
        end
        if (!mem_req) begin
            $display("store_hold: mem_req never rose");
            errors++;
        end
        check_value("store_hold", addr, mem_addr);
        check_value("store_hold", data, mem_data);
        repeat (delay) begin
            check_value("store_hold", 32'd0, 32'(commit_valid));
            check_value("store_hold", 32'd1, 32'(mem_req));
            @(negedge clk);
        end
        mem_ack = 1'b1;
        @(negedge clk);
        mem_ack = 1'b0;
        check_value("store_hold", 32'd0, 32'(mem_req));
        wait_commit("store_hold", c);
        check_value("store_hold", 32'(tag_s), 32'(c.tag));
        check_value("store_hold", 32'(rob_pkg::op_store), 32'(c.kind));
        expect_alu_commit("store_hold", tag_a, rd, val_a);
        @(negedge clk);
        check_value("store_hold", 32'd1, 32'(empty));
        report_test("store_hold", e0);
    endtask

    task automatic test_flush();
        logic [2:0]  tag_x;
        logic [2:0]  t;
        logic [31:0] v;
        logic [4:0]  rd;
        int          e0;
        e0 = errors;
        rd = random_rd();
        @(negedge clk);
        dispatch_one("flush", rob_pkg::op_alu, rd, 32'h0, tag_x);
        dispatch_one("flush", rob_pkg::op_alu, random_rd(), 32'h0, tag_x);
        check_value("flush", 32'd0, 32'(empty));
        read_reg(rd, t, v);
        if (t == 3'd0) begin
            $display("flush: rename of x%0d missing before flush", rd);
            errors++;
        end
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_value("flush", 32'd1, 32'(empty));
        check_value("flush", 32'd1, 32'(alloc_tag));
        for (int r = 0; r < 32; r++) begin
            read_reg(5'(r), t, v);
            check_value("flush", 32'd0, 32'(t));
            if (reg_known[r]) begin
                check_value("flush", reg_model[r], v);
            end
        end
        report_test("flush", e0);
    endtask

    // hang guard sized from the test budgets
    initial begin
        #(4 * TEST_BUDGET * NUM_TESTS);
        $display("run timed out before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        flush       = 1'b0;
        dispatch    = 1'b0;
        dispatch_op = '0;
        cdb         = '0;
        src_reg     = '0;
        mem_ack     = 1'b0;
        exp_tail    = 3'd1;
        exp_count   = 0;
        for (int r = 0; r < 32; r++) begin
            reg_known[r] = 1'b0;
            reg_model[r] = '0;
        end
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("reset", 32'd0, 32'(commit_valid));
        check_value("reset", 32'd0, 32'(mem_req));
        check_value("reset", 32'd0, 32'(full));
        test_in_order();
        test_renaming();
        test_full_wrap();
        test_store_hold();
        test_flush();
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
rtl/rob_pkg.sv
rtl/reorder_buffer.sv
rtl/rename_regfile.sv
rtl/store_commit.sv
rtl/rob_core.sv
testbench/rob_clock.sv
testbench/rob_properties.sv
testbench/rob_tb.sv

// File: run.sh
#!/bin/sh
# build and run the reorder buffer testbench, fail unless the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rob_tb -f project.f -o rob_sim \
    && ./obj_dir/rob_sim | tee /dev/stderr | grep -q "^Test OK$" \
    || exit 1
